// File: logic/ctrl_reg_pkg.sv
/* Status packet word order, DEV_STATUS bit positions,
   register word, count and size types */
package ctrl_reg_pkg;

  typedef logic [31:0] reg_word_t;
  typedef logic [31:0] data_count_t;
  typedef logic [23:0] fifo_size_t;

  // Words in one status packet
  localparam int REG_COUNT = 12;

  typedef enum logic [3:0] {
    STATUS_BUF_ADDR = 4'd0,
    BUFFER_READY    = 4'd1,
    WRITE_A         = 4'd2,
    WRITE_B         = 4'd3,
    READ_A          = 4'd4,
    READ_B          = 4'd5,
    BUFFER_SIZE     = 4'd6,
    PING_VALUE      = 4'd7,
    DEV_ADDR        = 4'd8,
    DEV_STATUS      = 4'd9,
    BUF_DONE        = 4'd10,
    INTERRUPT       = 4'd11
  } reg_idx_e;

  // DEV_STATUS bits, 16 and up read as zero
  localparam int STS_CMD_ERR        = 0;
  localparam int STS_RESET          = 1;
  localparam int STS_DONE           = 2;
  localparam int STS_READY          = 3;
  localparam int STS_WRITE          = 4;
  localparam int STS_READ           = 5;
  localparam int STS_FIFO           = 6;
  localparam int STS_PING           = 7;
  localparam int STS_READ_CFG       = 8;
  localparam int STS_UNKNOWN_CMD    = 9;
  localparam int STS_FIFO_STALL     = 10;
  localparam int STS_HOST_BUF_STALL = 11;
  localparam int STS_PERIPH         = 12;
  localparam int STS_MEM            = 13;
  localparam int STS_DMA            = 14;
  localparam int STS_INTERRUPT      = 15;

  localparam logic [7:0] MSI_CONFIG = 8'h00;

endpackage

// File: logic/tlp_pkg.sv
/* TLP field types, memory write command, flag value and config tag */
package tlp_pkg;

  typedef logic [7:0]  tlp_cmd_t;
  typedef logic [13:0] tlp_flags_t;
  typedef logic [31:0] tlp_addr_t;
  // Bus, device and function number
  typedef logic [15:0] req_id_t;
  typedef logic [7:0]  tlp_tag_t;

  // Memory write with 32-bit address
  localparam tlp_cmd_t   MWR_32B     = 8'h40;
  localparam tlp_flags_t FLAG_NORMAL = 14'h0000;
  // Status packets always go out with tag zero
  localparam tlp_tag_t   CFG_TAG     = 8'h00;

endpackage

// File: logic/cfg_req_if.sv
/* Status packet request link between command sequencer and config reporter */
`timescale 1ns/10ps

interface cfg_req_if;

  logic                    cfg_stb;
  // Sequencer owned DEV_STATUS bits only
  ctrl_reg_pkg::reg_word_t status;
  logic [1:0]              buf_rdy;
  logic [1:0]              buf_done;
  logic                    ctl_busy;
  logic                    cfg_idle;

  modport seq (
    output cfg_stb, status, buf_rdy, buf_done, ctl_busy,
    input  cfg_idle
  );

  modport rpt (
    input  cfg_stb, status, buf_rdy, buf_done, ctl_busy,
    output cfg_idle
  );

endinterface

// File: logic/ctrl_fifo.sv
/* 16 x 32-bit single-clock FIFO, valid/ready on both sides */
`timescale 1ns/10ps

module ctrl_fifo (
  input  logic                    clk,
  input  logic                    i_cmd_rst_stb,
  input  logic                    i_wr_valid,
  output logic                    o_wr_ready,
  input  ctrl_reg_pkg::reg_word_t i_wr_data,
  output logic                    o_rd_valid,
  input  logic                    i_rd_ready,
  output ctrl_reg_pkg::reg_word_t o_rd_data,
  output logic                    o_empty
);

  ctrl_reg_pkg::reg_word_t mem [16];
  logic [3:0]              r_wr_ptr;
  logic [3:0]              r_rd_ptr;
  logic [4:0]              r_count;
  logic                    w_push;
  logic                    w_pop;

  // Count bit 4 set means all 16 entries hold data
  assign o_wr_ready = ~r_count[4];
  assign o_rd_valid = (r_count != 5'd0);
  assign o_empty    = (r_count == 5'd0);
  assign o_rd_data  = mem[r_rd_ptr];
  assign w_push     = i_wr_valid & o_wr_ready;
  assign w_pop      = o_rd_valid & i_rd_ready;

  always_ff @(posedge clk) begin
    if (w_push) begin
      mem[r_wr_ptr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (i_cmd_rst_stb) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (w_push) begin
        r_wr_ptr <= r_wr_ptr + 4'd1;
      end
      if (w_pop) begin
        r_rd_ptr <= r_rd_ptr + 4'd1;
      end
      case ({w_push, w_pop})
        2'b10:   r_count <= r_count + 5'd1;
        2'b01:   r_count <= r_count - 5'd1;
        default: r_count <= r_count;
      endcase
    end
  end

endmodule

// File: logic/cmd_sequencer.sv
/* Command FSM with egress block loop, host buffer selection and status bits */
`timescale 1ns/10ps

module cmd_sequencer (
  input  logic                      clk,
  input  logic                      i_cmd_rst_stb,
  input  logic                      i_cmd_rd_stb,
  input  logic                      i_cmd_flg_fifo,
  input  logic                      i_cmd_flg_sel_periph,
  input  logic                      i_cmd_flg_sel_memory,
  input  logic                      i_cmd_flg_sel_dma,
  input  ctrl_reg_pkg::data_count_t i_cmd_data_count,
  input  ctrl_reg_pkg::reg_word_t   i_cmd_data_address,
  input  logic [1:0]                i_update_buf,
  input  logic                      i_update_buf_stb,
  input  logic                      i_e_fifo_rdy,
  input  ctrl_reg_pkg::fifo_size_t  i_e_fifo_size,
  input  tlp_pkg::tlp_addr_t        i_read_a_addr,
  input  tlp_pkg::tlp_addr_t        i_read_b_addr,
  input  logic                      i_egress_finished,
  output logic                      o_per_sel,
  output logic                      o_mem_sel,
  output logic                      o_dma_sel,
  output ctrl_reg_pkg::data_count_t o_data_size,
  output ctrl_reg_pkg::reg_word_t   o_data_address,
  output logic                      o_data_fifo_flg,
  output logic                      o_data_read_flg,
  output logic                      o_data_en,
  output tlp_pkg::tlp_addr_t        o_data_addr,
  output tlp_pkg::tlp_tag_t         o_data_tag,
  cfg_req_if.seq                    cfg
);

  typedef enum logic [2:0] {
    IDLE,
    EGRESS_FLOW,
    WAIT_E_FIFO,
    WAIT_HOST_BUF,
    SEND_DATA,
    SEND_CFG,
    WAIT_CFG_ACK,
    WAIT_CFG_DONE
  } seq_state_e;

  seq_state_e                state;
  ctrl_reg_pkg::data_count_t r_data_count;
  logic [1:0]                r_buf_rdy;
  logic [1:0]                r_buf_sel;
  logic [1:0]                r_buf_done;
  logic                      r_next_b;
  logic                      r_last_cfg;
  logic                      r_sts_cmd_err;
  logic                      r_sts_reset;
  logic                      r_sts_done;
  logic                      w_bus_sel;

  assign w_bus_sel    = i_cmd_flg_sel_periph | i_cmd_flg_sel_memory | i_cmd_flg_sel_dma;
  assign cfg.buf_rdy  = r_buf_rdy;
  assign cfg.buf_done = r_buf_done;
  assign cfg.ctl_busy = (state == SEND_DATA);

  always_comb begin
    cfg.status = '0;
    cfg.status[ctrl_reg_pkg::STS_CMD_ERR]        = r_sts_cmd_err;
    cfg.status[ctrl_reg_pkg::STS_RESET]          = r_sts_reset;
    cfg.status[ctrl_reg_pkg::STS_DONE]           = r_sts_done;
    cfg.status[ctrl_reg_pkg::STS_READY]          = (state == IDLE);
    // No ingress path in this block
    cfg.status[ctrl_reg_pkg::STS_WRITE]          = 1'b0;
    cfg.status[ctrl_reg_pkg::STS_READ]           = o_data_read_flg;
    cfg.status[ctrl_reg_pkg::STS_FIFO]           = o_data_fifo_flg;
    cfg.status[ctrl_reg_pkg::STS_FIFO_STALL]     = (state == WAIT_E_FIFO);
    cfg.status[ctrl_reg_pkg::STS_HOST_BUF_STALL] = (state == WAIT_HOST_BUF);
    cfg.status[ctrl_reg_pkg::STS_PERIPH]         = o_per_sel;
    cfg.status[ctrl_reg_pkg::STS_MEM]            = o_mem_sel;
    cfg.status[ctrl_reg_pkg::STS_DMA]            = o_dma_sel;
  end

  always_ff @(posedge clk) begin
    if (i_cmd_rst_stb) begin
      // Report the reset to the host right away
      state           <= WAIT_CFG_ACK;
      cfg.cfg_stb     <= 1'b1;
      r_sts_reset     <= 1'b1;
      r_last_cfg      <= 1'b1;
      r_sts_cmd_err   <= 1'b0;
      r_sts_done      <= 1'b0;
      r_buf_rdy       <= '0;
      r_buf_sel       <= '0;
      r_buf_done      <= '0;
      r_next_b        <= 1'b0;
      r_data_count    <= '0;
      o_per_sel       <= 1'b0;
      o_mem_sel       <= 1'b0;
      o_dma_sel       <= 1'b0;
      o_data_fifo_flg <= 1'b0;
      o_data_read_flg <= 1'b0;
      o_data_en       <= 1'b0;
      o_data_tag      <= '0;
    end else begin
      cfg.cfg_stb <= 1'b0;
      if (i_update_buf_stb) begin
        r_buf_rdy <= i_update_buf;
      end
      case (state)
        IDLE: begin
          r_sts_cmd_err   <= 1'b0;
          r_sts_reset     <= 1'b0;
          r_sts_done      <= 1'b0;
          r_data_count    <= '0;
          r_next_b        <= 1'b0;
          o_data_tag      <= '0;
          o_data_size     <= i_cmd_data_count;
          o_data_address  <= i_cmd_data_address;
          o_data_fifo_flg <= i_cmd_flg_fifo;
          o_per_sel       <= i_cmd_flg_sel_periph;
          o_mem_sel       <= i_cmd_flg_sel_memory;
          o_dma_sel       <= i_cmd_flg_sel_dma;
          o_data_read_flg <= 1'b0;
          if (i_cmd_rd_stb) begin
            if (w_bus_sel) begin
              o_data_read_flg <= 1'b1;
              state           <= EGRESS_FLOW;
            end else begin
              // Read with no bus selected
              r_sts_cmd_err <= 1'b1;
              r_last_cfg    <= 1'b1;
              state         <= SEND_CFG;
            end
          end
        end
        EGRESS_FLOW: begin
          if (r_data_count < o_data_size) begin
            state <= WAIT_E_FIFO;
          end else begin
            r_sts_done <= 1'b1;
            r_last_cfg <= 1'b1;
            state      <= SEND_CFG;
          end
        end
        WAIT_E_FIFO: begin
          if (i_e_fifo_rdy) begin
            state <= WAIT_HOST_BUF;
          end
        end
        WAIT_HOST_BUF: begin
          // Egress port is shared, so hold off while a packet is pending
          if (cfg.cfg_idle && (r_buf_rdy != 2'b00)) begin
            o_data_en <= 1'b1;
            state     <= SEND_DATA;
            if (r_buf_rdy[0] && (!r_buf_rdy[1] || !r_next_b)) begin
              r_buf_sel   <= 2'b01;
              o_data_addr <= i_read_a_addr;
              r_next_b    <= 1'b1;
            end else begin
              r_buf_sel   <= 2'b10;
              o_data_addr <= i_read_b_addr;
              r_next_b    <= 1'b0;
            end
          end
        end
        SEND_DATA: begin
          if (i_egress_finished) begin
            o_data_en    <= 1'b0;
            r_data_count <= r_data_count + ctrl_reg_pkg::data_count_t'(i_e_fifo_size);
            r_buf_done   <= r_buf_sel;
            r_buf_sel    <= '0;
            o_data_tag   <= o_data_tag + 8'd1;
            r_last_cfg   <= 1'b0;
            state        <= SEND_CFG;
          end
        end
        SEND_CFG: begin
          if (cfg.cfg_idle) begin
            cfg.cfg_stb <= 1'b1;
            state       <= WAIT_CFG_ACK;
          end
        end
        WAIT_CFG_ACK: begin
          // Block packets let the loop go on, final ones wait for the interrupt
          if (!cfg.cfg_idle) begin
            state <= r_last_cfg ? WAIT_CFG_DONE : EGRESS_FLOW;
          end
        end
        WAIT_CFG_DONE: begin
          if (cfg.cfg_idle) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: logic/cfg_reporter.sv
/* Status packet loader, config TLP request and MSI interrupt strobe */
`timescale 1ns/10ps

module cfg_reporter (
  input  logic                    clk,
  input  logic                    i_cmd_rst_stb,
  input  logic                    i_cmd_ping_stb,
  input  logic                    i_cmd_rd_cfg_stb,
  input  logic                    i_cmd_unknown,
  input  logic                    i_interrupt_stb,
  input  ctrl_reg_pkg::reg_word_t i_interrupt_sts,
  input  ctrl_reg_pkg::reg_word_t i_status_addr,
  input  ctrl_reg_pkg::reg_word_t i_write_a_addr,
  input  ctrl_reg_pkg::reg_word_t i_write_b_addr,
  input  ctrl_reg_pkg::reg_word_t i_read_a_addr,
  input  ctrl_reg_pkg::reg_word_t i_read_b_addr,
  input  ctrl_reg_pkg::reg_word_t i_buffer_size,
  input  ctrl_reg_pkg::reg_word_t i_ping_value,
  input  ctrl_reg_pkg::reg_word_t i_dev_addr,
  input  logic                    i_fifo_empty,
  input  logic                    i_wr_ready,
  input  logic                    i_egress_finished,
  output logic                    o_wr_valid,
  output ctrl_reg_pkg::reg_word_t o_wr_data,
  output logic                    o_cfg_en,
  output logic                    o_ctr_sel,
  output logic                    o_interrupt_stb,
  output logic [7:0]              o_interrupt_msi_value,
  cfg_req_if.rpt                  cfg
);

  typedef enum logic [1:0] {
    IDLE,
    PREPARE,
    LOAD,
    SEND
  } rpt_state_e;

  rpt_state_e              state;
  ctrl_reg_pkg::reg_idx_e  r_idx;
  ctrl_reg_pkg::reg_word_t r_seq_status;
  ctrl_reg_pkg::reg_word_t w_dev_status;
  ctrl_reg_pkg::reg_word_t w_map [ctrl_reg_pkg::REG_COUNT];
  logic                    r_sts_ping;
  logic                    r_sts_read_cfg;
  logic                    r_sts_unknown;
  logic                    r_sts_interrupt;
  logic                    w_start;

  assign cfg.cfg_idle          = (state == IDLE);
  assign o_wr_valid            = (state == LOAD);
  assign o_wr_data             = w_map[r_idx];
  assign o_interrupt_msi_value = ctrl_reg_pkg::MSI_CONFIG;
  assign w_start = i_cmd_ping_stb | i_cmd_rd_cfg_stb | cfg.cfg_stb | i_interrupt_stb;

  always_comb begin
    w_dev_status = r_seq_status;
    w_dev_status[ctrl_reg_pkg::STS_PING]        = r_sts_ping;
    w_dev_status[ctrl_reg_pkg::STS_READ_CFG]    = r_sts_read_cfg;
    w_dev_status[ctrl_reg_pkg::STS_UNKNOWN_CMD] = r_sts_unknown;
    w_dev_status[ctrl_reg_pkg::STS_INTERRUPT]   = r_sts_interrupt;
  end

  always_comb begin
    w_map[ctrl_reg_pkg::STATUS_BUF_ADDR] = i_status_addr;
    w_map[ctrl_reg_pkg::BUFFER_READY]    = {30'h0, cfg.buf_rdy};
    w_map[ctrl_reg_pkg::WRITE_A]         = i_write_a_addr;
    w_map[ctrl_reg_pkg::WRITE_B]         = i_write_b_addr;
    w_map[ctrl_reg_pkg::READ_A]          = i_read_a_addr;
    w_map[ctrl_reg_pkg::READ_B]          = i_read_b_addr;
    w_map[ctrl_reg_pkg::BUFFER_SIZE]     = i_buffer_size;
    w_map[ctrl_reg_pkg::PING_VALUE]      = i_ping_value;
    w_map[ctrl_reg_pkg::DEV_ADDR]        = i_dev_addr;
    w_map[ctrl_reg_pkg::DEV_STATUS]      = w_dev_status;
    w_map[ctrl_reg_pkg::BUF_DONE]        = {30'h0, cfg.buf_done};
    w_map[ctrl_reg_pkg::INTERRUPT]       = i_interrupt_sts;
  end

  always_ff @(posedge clk) begin
    if (i_cmd_rst_stb) begin
      state           <= IDLE;
      r_idx           <= ctrl_reg_pkg::STATUS_BUF_ADDR;
      o_cfg_en        <= 1'b0;
      o_ctr_sel       <= 1'b0;
      o_interrupt_stb <= 1'b0;
      r_sts_ping      <= 1'b0;
      r_sts_read_cfg  <= 1'b0;
      r_sts_unknown   <= 1'b0;
      r_sts_interrupt <= 1'b0;
    end else begin
      o_interrupt_stb <= 1'b0;
      case (state)
        IDLE: begin
          // Priority is ping, read-config, sequencer, interrupt
          r_sts_ping      <= i_cmd_ping_stb;
          r_sts_read_cfg  <= i_cmd_rd_cfg_stb & ~i_cmd_ping_stb;
          r_sts_interrupt <= i_interrupt_stb &
                             ~(i_cmd_ping_stb | i_cmd_rd_cfg_stb | cfg.cfg_stb);
          r_sts_unknown   <= i_cmd_unknown;
          if (w_start) begin
            state <= PREPARE;
          end
        end
        PREPARE: begin
          // Keep a packet contiguous and off the port during a data block
          if (i_fifo_empty && !cfg.ctl_busy) begin
            o_ctr_sel    <= 1'b1;
            r_idx        <= ctrl_reg_pkg::STATUS_BUF_ADDR;
            r_seq_status <= cfg.status;
            state        <= LOAD;
          end
        end
        LOAD: begin
          if (i_wr_ready) begin
            if (r_idx == ctrl_reg_pkg::INTERRUPT) begin
              o_cfg_en <= 1'b1;
              state    <= SEND;
            end else begin
              r_idx <= ctrl_reg_pkg::reg_idx_e'(r_idx + 4'd1);
            end
          end
        end
        SEND: begin
          if (i_egress_finished) begin
            o_cfg_en        <= 1'b0;
            o_ctr_sel       <= 1'b0;
            o_interrupt_stb <= 1'b1;
            state           <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: logic/pcie_control.sv
/* PCIe control top level with sequencer, reporter, packet FIFO
   and egress TLP field selection */
`timescale 1ns/10ps

module pcie_control (
  input  logic                      clk,
  input  logic                      i_cmd_rst_stb,
  input  logic [7:0]                i_pcie_bus_num,
  input  logic [4:0]                i_pcie_dev_num,
  input  logic [2:0]                i_pcie_fun_num,
  input  logic                      i_cmd_rd_stb,
  input  logic                      i_cmd_flg_fifo,
  input  logic                      i_cmd_flg_sel_periph,
  input  logic                      i_cmd_flg_sel_memory,
  input  logic                      i_cmd_flg_sel_dma,
  input  logic                      i_cmd_ping_stb,
  input  logic                      i_cmd_rd_cfg_stb,
  input  logic                      i_cmd_unknown,
  input  ctrl_reg_pkg::data_count_t i_cmd_data_count,
  input  ctrl_reg_pkg::reg_word_t   i_cmd_data_address,
  input  tlp_pkg::tlp_addr_t        i_status_addr,
  input  tlp_pkg::tlp_addr_t        i_write_a_addr,
  input  tlp_pkg::tlp_addr_t        i_write_b_addr,
  input  tlp_pkg::tlp_addr_t        i_read_a_addr,
  input  tlp_pkg::tlp_addr_t        i_read_b_addr,
  input  ctrl_reg_pkg::reg_word_t   i_buffer_size,
  input  ctrl_reg_pkg::reg_word_t   i_ping_value,
  input  ctrl_reg_pkg::reg_word_t   i_dev_addr,
  input  logic [1:0]                i_update_buf,
  input  logic                      i_update_buf_stb,
  input  ctrl_reg_pkg::reg_word_t   i_interrupt_sts,
  input  logic                      i_interrupt_stb,
  input  logic                      i_e_fifo_rdy,
  input  ctrl_reg_pkg::fifo_size_t  i_e_fifo_size,
  output logic                      o_per_sel,
  output logic                      o_mem_sel,
  output logic                      o_dma_sel,
  output ctrl_reg_pkg::data_count_t o_data_size,
  output ctrl_reg_pkg::reg_word_t   o_data_address,
  output logic                      o_data_fifo_flg,
  output logic                      o_data_read_flg,
  output logic                      o_egress_enable,
  input  logic                      i_egress_finished,
  output tlp_pkg::tlp_cmd_t         o_egress_tlp_command,
  output tlp_pkg::tlp_flags_t       o_egress_tlp_flags,
  output tlp_pkg::tlp_addr_t        o_egress_tlp_address,
  output tlp_pkg::req_id_t          o_egress_tlp_requester_id,
  output tlp_pkg::tlp_tag_t         o_egress_tag,
  output logic                      o_ctr_sel,
  output logic                      o_interrupt_stb,
  output logic [7:0]                o_interrupt_msi_value,
  output logic                      o_egress_fifo_valid,
  input  logic                      i_egress_fifo_ready,
  output ctrl_reg_pkg::reg_word_t   o_egress_fifo_data,
  output logic                      o_sys_rst
);

  logic                    w_cfg_en;
  logic                    w_data_en;
  tlp_pkg::tlp_addr_t      w_data_addr;
  tlp_pkg::tlp_tag_t       w_data_tag;
  logic                    w_wr_valid;
  logic                    w_wr_ready;
  ctrl_reg_pkg::reg_word_t w_wr_data;
  logic                    w_fifo_empty;

  cfg_req_if u_cfg_req ();

  assign o_sys_rst       = i_cmd_rst_stb;
  // Reporter and sequencer never hold the port together
  assign o_egress_enable = w_cfg_en | w_data_en;

  // Both owners send memory writes
  assign o_egress_tlp_command      = tlp_pkg::MWR_32B;
  assign o_egress_tlp_flags        = tlp_pkg::FLAG_NORMAL;
  assign o_egress_tlp_address      = w_cfg_en ? i_status_addr : w_data_addr;
  assign o_egress_tag              = w_cfg_en ? tlp_pkg::CFG_TAG : w_data_tag;
  assign o_egress_tlp_requester_id = {i_pcie_bus_num, i_pcie_dev_num, i_pcie_fun_num};

  cmd_sequencer u_cmd_sequencer (
    .*,
    .o_data_en   (w_data_en),
    .o_data_addr (w_data_addr),
    .o_data_tag  (w_data_tag),
    .cfg         (u_cfg_req.seq)
  );

  cfg_reporter u_cfg_reporter (
    .*,
    .i_fifo_empty (w_fifo_empty),
    .i_wr_ready   (w_wr_ready),
    .o_wr_valid   (w_wr_valid),
    .o_wr_data    (w_wr_data),
    .o_cfg_en     (w_cfg_en),
    .cfg          (u_cfg_req.rpt)
  );

  ctrl_fifo u_ctrl_fifo (
    .clk           (clk),
    .i_cmd_rst_stb (i_cmd_rst_stb),
    .i_wr_valid    (w_wr_valid),
    .o_wr_ready    (w_wr_ready),
    .i_wr_data     (w_wr_data),
    .o_rd_valid    (o_egress_fifo_valid),
    .i_rd_ready    (i_egress_fifo_ready),
    .o_rd_data     (o_egress_fifo_data),
    .o_empty       (w_fifo_empty)
  );

endmodule

// File: dv/tb_pcie_control.sv
/* Testbench for pcie_control with file-driven commands, host FIFO drain,
   egress port model and packet and TLP checks */
`timescale 1ns/10ps

module tb_pcie_control;

  localparam int          WAIT_LIMIT = 400;
  localparam logic [7:0]  EXP_CMD    = 8'h40;
  localparam logic [13:0] EXP_FLAGS  = 14'h0000;
  localparam logic [7:0]  EXP_MSI    = 8'h00;

  logic        clk;
  logic        i_cmd_rst_stb;
  logic [7:0]  i_pcie_bus_num;
  logic [4:0]  i_pcie_dev_num;
  logic [2:0]  i_pcie_fun_num;
  logic        i_cmd_rd_stb;
  logic        i_cmd_flg_fifo;
  logic        i_cmd_flg_sel_periph;
  logic        i_cmd_flg_sel_memory;
  logic        i_cmd_flg_sel_dma;
  logic        i_cmd_ping_stb;
  logic        i_cmd_rd_cfg_stb;
  logic        i_cmd_unknown;
  logic [31:0] i_cmd_data_count;
  logic [31:0] i_cmd_data_address;
  logic [31:0] i_status_addr;
  logic [31:0] i_write_a_addr;
  logic [31:0] i_write_b_addr;
  logic [31:0] i_read_a_addr;
  logic [31:0] i_read_b_addr;
  logic [31:0] i_buffer_size;
  logic [31:0] i_ping_value;
  logic [31:0] i_dev_addr;
  logic [1:0]  i_update_buf;
  logic        i_update_buf_stb;
  logic [31:0] i_interrupt_sts;
  logic        i_interrupt_stb;
  logic        i_e_fifo_rdy;
  logic [23:0] i_e_fifo_size;
  logic        i_egress_finished;
  logic        i_egress_fifo_ready;
  logic        o_per_sel;
  logic        o_mem_sel;
  logic        o_dma_sel;
  logic [31:0] o_data_size;
  logic [31:0] o_data_address;
  logic        o_data_fifo_flg;
  logic        o_data_read_flg;
  logic        o_egress_enable;
  logic [7:0]  o_egress_tlp_command;
  logic [13:0] o_egress_tlp_flags;
  logic [31:0] o_egress_tlp_address;
  logic [15:0] o_egress_tlp_requester_id;
  logic [7:0]  o_egress_tag;
  logic        o_ctr_sel;
  logic        o_interrupt_stb;
  logic [7:0]  o_interrupt_msi_value;
  logic        o_egress_fifo_valid;
  logic [31:0] o_egress_fifo_data;
  logic        o_sys_rst;

  int          fd;
  logic [31:0] args [11];
  // Packet words that come straight from the configured inputs
  logic [31:0] cfg_words [12];
  logic [15:0] exp_req_id;
  // Settings of the last read command
  logic [3:0]  exp_read_flags;
  logic [31:0] exp_data_size;
  logic [31:0] exp_data_address;

  pcie_control u_pcie_control (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic skip_line();
    int ch;
    ch = 0;
    while (ch != 10 && ch != -1) begin
      ch = $fgetc(fd);
    end
  endtask

  task automatic read_args(input int count);
    logic [31:0] value;
    int          code;
    int          idx;
    for (idx = 0; idx < count; idx++) begin
      code = $fscanf(fd, "%h", value);
      if (code != 1) begin
        abort_run("Stimulus record has too few arguments");
      end
      args[idx] = value;
    end
  endtask

  // Host side pops one packet word while ready toggles at random
  task automatic receive_word(output logic [31:0] word);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    while (!got) begin
      @(negedge clk);
      i_egress_fifo_ready = (($urandom % 3) != 0);
      if (o_egress_fifo_valid && i_egress_fifo_ready) begin
        word = o_egress_fifo_data;
        got  = 1'b1;
      end else begin
        waited++;
        if (waited > WAIT_LIMIT) begin
          abort_run("Timeout waiting for a status packet word");
        end
      end
    end
  endtask

  task automatic wait_enable();
    int waited;
    waited = 0;
    while (!o_egress_enable) begin
      @(negedge clk);
      i_egress_fifo_ready = 1'b0;
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("Timeout waiting for the egress enable");
      end
    end
  endtask

  task automatic check_tlp(input logic [31:0] addr, input logic [7:0] tag);
    check_value("o_egress_tlp_command", o_egress_tlp_command, EXP_CMD);
    check_value("o_egress_tlp_flags", o_egress_tlp_flags, EXP_FLAGS);
    check_value("o_egress_tlp_address", o_egress_tlp_address, addr);
    check_value("o_egress_tag", o_egress_tag, tag);
    check_value("o_egress_tlp_requester_id", o_egress_tlp_requester_id, exp_req_id);
  endtask

  // Read command outputs held by the sequencer during a block
  task automatic check_read_cmd();
    check_value("o_data_read_flg", o_data_read_flg, 32'h1);
    check_value("o_per_sel", o_per_sel, exp_read_flags[0]);
    check_value("o_mem_sel", o_mem_sel, exp_read_flags[1]);
    check_value("o_dma_sel", o_dma_sel, exp_read_flags[2]);
    check_value("o_data_fifo_flg", o_data_fifo_flg, exp_read_flags[3]);
    check_value("o_data_size", o_data_size, exp_data_size);
    check_value("o_data_address", o_data_address, exp_data_address);
  endtask

  // Egress engine latency followed by the finished pulse
  task automatic finish_send(input logic is_cfg);
    int delay;
    @(negedge clk);
    i_egress_fifo_ready = 1'b0;
    delay = $urandom % 4;
    repeat (delay) @(negedge clk);
    check_value("o_egress_enable", o_egress_enable, 32'h1);
    check_value("o_interrupt_stb", o_interrupt_stb, 32'h0);
    i_egress_finished = 1'b1;
    @(negedge clk);
    i_egress_finished = 1'b0;
    check_value("o_egress_enable", o_egress_enable, 32'h0);
    check_value("o_interrupt_stb", o_interrupt_stb, is_cfg);
    if (is_cfg) begin
      check_value("o_interrupt_msi_value", o_interrupt_msi_value, EXP_MSI);
      @(negedge clk);
      check_value("o_interrupt_stb", o_interrupt_stb, 32'h0);
    end
  endtask

  task automatic expect_packet(input logic [31:0] buf_ready, input logic [31:0] dev_status,
                               input logic [31:0] buf_done, input logic [31:0] intr_word);
    logic [31:0] exp_words [12];
    logic [31:0] word;
    int          idx;
    for (idx = 0; idx < 12; idx++) begin
      exp_words[idx] = cfg_words[idx];
    end
    exp_words[1]  = buf_ready;
    exp_words[9]  = dev_status;
    exp_words[10] = buf_done;
    exp_words[11] = intr_word;
    for (idx = 0; idx < 12; idx++) begin
      receive_word(word);
      check_value($sformatf("o_egress_fifo_data[%0d]", idx), word, exp_words[idx]);
    end
    wait_enable();
    check_value("o_ctr_sel", o_ctr_sel, 32'h1);
    check_tlp(cfg_words[0], 8'h00);
    finish_send(1'b1);
  endtask

  task automatic expect_block(input logic [31:0] addr, input logic [7:0] tag);
    wait_enable();
    // A data block leaves the packet FIFO empty
    check_value("o_egress_fifo_valid", o_egress_fifo_valid, 32'h0);
    check_value("o_ctr_sel", o_ctr_sel, 32'h0);
    check_tlp(addr, tag);
    check_read_cmd();
    finish_send(1'b0);
  endtask

  task automatic run_record(input logic [63:0] op);
    if (op == "cfg") begin
      read_args(11);
      i_status_addr  = args[0];
      i_write_a_addr = args[1];
      i_write_b_addr = args[2];
      i_read_a_addr  = args[3];
      i_read_b_addr  = args[4];
      i_buffer_size  = args[5];
      i_ping_value   = args[6];
      i_dev_addr     = args[7];
      i_pcie_bus_num = args[8][7:0];
      i_pcie_dev_num = args[9][4:0];
      i_pcie_fun_num = args[10][2:0];
      cfg_words[0]   = args[0];
      cfg_words[2]   = args[1];
      cfg_words[3]   = args[2];
      cfg_words[4]   = args[3];
      cfg_words[5]   = args[4];
      cfg_words[6]   = args[5];
      cfg_words[7]   = args[6];
      cfg_words[8]   = args[7];
      // Bus, device, function
      exp_req_id     = {args[8][7:0], args[9][4:0], args[10][2:0]};
    end else if (op == "ping") begin
      i_cmd_ping_stb = 1'b1;
      @(negedge clk);
      i_cmd_ping_stb = 1'b0;
    end else if (op == "rdcfg") begin
      read_args(1);
      i_cmd_rd_cfg_stb = 1'b1;
      i_cmd_unknown    = args[0][0];
      @(negedge clk);
      i_cmd_rd_cfg_stb = 1'b0;
      i_cmd_unknown    = 1'b0;
    end else if (op == "intr") begin
      read_args(1);
      i_interrupt_sts = args[0];
      i_interrupt_stb = 1'b1;
      @(negedge clk);
      i_interrupt_stb = 1'b0;
    end else if (op == "bufs") begin
      read_args(1);
      i_update_buf     = args[0][1:0];
      i_update_buf_stb = 1'b1;
      @(negedge clk);
      i_update_buf_stb = 1'b0;
    end else if (op == "read") begin
      read_args(4);
      // Bit 3 of the select mask is the FIFO flag
      i_cmd_flg_sel_periph = args[0][0];
      i_cmd_flg_sel_memory = args[0][1];
      i_cmd_flg_sel_dma    = args[0][2];
      i_cmd_flg_fifo       = args[0][3];
      i_cmd_data_count     = args[1];
      i_e_fifo_size        = args[2][23:0];
      i_cmd_data_address   = args[3];
      exp_read_flags       = args[0][3:0];
      exp_data_size        = args[1];
      exp_data_address     = args[3];
      i_e_fifo_rdy         = 1'b1;
      i_cmd_rd_stb         = 1'b1;
      @(negedge clk);
      i_cmd_rd_stb         = 1'b0;
      i_cmd_flg_sel_periph = 1'b0;
      i_cmd_flg_sel_memory = 1'b0;
      i_cmd_flg_sel_dma    = 1'b0;
      i_cmd_flg_fifo       = 1'b0;
    end else if (op == "pkt") begin
      read_args(4);
      expect_packet(args[0], args[1], args[2], args[3]);
    end else if (op == "blk") begin
      read_args(2);
      expect_block(args[0], args[1][7:0]);
    end else if (op == "rst") begin
      i_cmd_rst_stb = 1'b1;
      @(posedge clk);
      check_value("o_sys_rst", o_sys_rst, 32'h1);
      @(negedge clk);
      i_cmd_rst_stb = 1'b0;
    end else if (op == "quiet") begin
      read_args(1);
      repeat (args[0]) begin
        @(negedge clk);
        check_value("o_egress_enable", o_egress_enable, 32'h0);
        check_value("o_egress_fifo_valid", o_egress_fifo_valid, 32'h0);
      end
    end else begin
      abort_run("Unknown record in the stimulus file");
    end
  endtask

  initial begin
    int          seed_val;
    int          code;
    int          idx;
    logic        done;
    logic [63:0] op;
    seed_val             = $urandom(32'h8203_604a);
    i_cmd_rst_stb        = 1'b1;
    i_pcie_bus_num       = '0;
    i_pcie_dev_num       = '0;
    i_pcie_fun_num       = '0;
    i_cmd_rd_stb         = 1'b0;
    i_cmd_flg_fifo       = 1'b0;
    i_cmd_flg_sel_periph = 1'b0;
    i_cmd_flg_sel_memory = 1'b0;
    i_cmd_flg_sel_dma    = 1'b0;
    i_cmd_ping_stb       = 1'b0;
    i_cmd_rd_cfg_stb     = 1'b0;
    i_cmd_unknown        = 1'b0;
    i_cmd_data_count     = '0;
    i_cmd_data_address   = '0;
    i_status_addr        = '0;
    i_write_a_addr       = '0;
    i_write_b_addr       = '0;
    i_read_a_addr        = '0;
    i_read_b_addr        = '0;
    i_buffer_size        = '0;
    i_ping_value         = '0;
    i_dev_addr           = '0;
    i_update_buf         = '0;
    i_update_buf_stb     = 1'b0;
    i_interrupt_sts      = '0;
    i_interrupt_stb      = 1'b0;
    i_e_fifo_rdy         = 1'b0;
    i_e_fifo_size        = '0;
    i_egress_finished    = 1'b0;
    i_egress_fifo_ready  = 1'b0;
    exp_req_id           = '0;
    exp_read_flags       = '0;
    exp_data_size        = '0;
    exp_data_address     = '0;
    for (idx = 0; idx < 12; idx++) begin
      cfg_words[idx] = '0;
    end
    repeat (3) @(negedge clk);
    i_cmd_rst_stb = 1'b0;
    fd = $fopen("dv/pcie_control_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the stimulus file dv/pcie_control_stimulus.txt");
    end
    done = 1'b0;
    while (!done) begin
      op   = '0;
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        skip_line();
      end else begin
        run_record(op);
      end
    end
    $fclose(fd);
    $display("Regression passed");
    $finish;
  end

endmodule

// File: dv/pcie_control_stimulus.txt
# cfg: status wr_a wr_b rd_a rd_b buf_size ping dev_addr bus dev fun; bufs: mask; intr: sts
# read: sel(dma mem periph) count fifo_size addr; pkt: buf_rdy dev_status buf_done intr; blk: addr tag
cfg 10000000 20000000 20001000 30000000 30001000 00000400 5a5a0001 000000c8 03 05 1
pkt 0 00000002 0 00000000
ping
pkt 0 00000088 0 00000000
read 0 00000180 000080 40000000
pkt 0 00000001 0 00000000
quiet 10
bufs 3
read 1 00000180 000080 40000000
blk 30000000 00
pkt 3 00001020 1 00000000
blk 30001000 01
pkt 3 00001020 2 00000000
blk 30000000 02
pkt 3 00001020 1 00000000
pkt 3 00001024 1 00000000
intr cafe0011
pkt 3 00008008 1 cafe0011
rdcfg 1
pkt 3 00000308 1 cafe0011
rst
pkt 0 00000002 0 cafe0011

// File: pcie_control.f
logic/ctrl_reg_pkg.sv
logic/tlp_pkg.sv
logic/cfg_req_if.sv
logic/ctrl_fifo.sv
logic/cmd_sequencer.sv
logic/cfg_reporter.sv
logic/pcie_control.sv
dv/tb_pcie_control.sv

// File: Bender.yml
package:
  name: pcie_control

sources:
  - logic/ctrl_reg_pkg.sv
  - logic/tlp_pkg.sv
  - logic/cfg_req_if.sv
  - logic/ctrl_fifo.sv
  - logic/cmd_sequencer.sv
  - logic/cfg_reporter.sv
  - logic/pcie_control.sv
  - target: test
    files:
      - dv/tb_pcie_control.sv
